/* files.f */
source/execute_pkg.sv
source/operand_bypass.sv
source/int_alu.sv
source/branch_resolve.sv
source/multiply_pipe.sv
source/result_merge.sv
source/execute_stage.sv
bench/execute_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module execute_stage_tb -f files.f -o sim_execute_stage
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_execute_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF '** PASS **'; then
	exit 0
fi
exit 1

/* bench/execute_stage_tb.sv */
// Directed testbench for the execute stage with an ALU reference model and a cycle timeout
`default_nettype none

module execute_stage_tb
	import execute_pkg::*;
();

	localparam int WORD_BITS = 32;
	localparam int REG_BITS = 5;
	localparam int MUL_STAGES = 3;
	// Multiply result shows this many cycles after issue
	localparam int MUL_LATENCY = MUL_STAGES + 1;
	localparam logic [WORD_BITS - 1:0] BRANCH_OFFSET = 32'h0000_0040;
	// Tests need under 200 cycles
	localparam int TIMEOUT_CYCLES = 400;

	logic clk;
	logic reset;
	logic ds_valid;
	logic [WORD_BITS - 1:0] ds_pc;
	alu_op_t ds_alu_op;
	logic [REG_BITS - 1:0] ds_sel1;
	logic [REG_BITS - 1:0] ds_sel2;
	logic ds_op2_is_imm;
	logic [WORD_BITS - 1:0] ds_immediate;
	logic [REG_BITS - 1:0] ds_writeback_reg;
	logic ds_writeback_en;
	branch_t ds_branch_type;
	logic [WORD_BITS - 1:0] ds_branch_offset;
	logic ds_branch_predicted;
	logic [WORD_BITS - 1:0] rf_value1;
	logic [WORD_BITS - 1:0] rf_value2;
	logic [REG_BITS - 1:0] ma_writeback_reg;
	logic ma_writeback_en;
	logic [WORD_BITS - 1:0] ma_result;
	logic [REG_BITS - 1:0] wb_writeback_reg;
	logic wb_writeback_en;
	logic [WORD_BITS - 1:0] wb_result;
	logic [MUL_STAGES:0] rb_squash;
	logic ex_valid;
	logic [WORD_BITS - 1:0] ex_pc;
	logic [REG_BITS - 1:0] ex_writeback_reg;
	logic ex_writeback_en;
	logic [WORD_BITS - 1:0] ex_result;
	logic ex_rollback;
	logic [WORD_BITS - 1:0] ex_rollback_pc;

	int errors;
	int checks;
	int cycles;
	logic [WORD_BITS - 1:0] rng_state;

	execute_stage #(.MUL_STAGES(MUL_STAGES)) dut_i (
		.clk(clk),
		.reset(reset),
		.ds_valid_i(ds_valid),
		.ds_pc_i(ds_pc),
		.ds_alu_op_i(ds_alu_op),
		.ds_sel1_i(ds_sel1),
		.ds_sel2_i(ds_sel2),
		.ds_op2_is_imm_i(ds_op2_is_imm),
		.ds_immediate_i(ds_immediate),
		.ds_writeback_reg_i(ds_writeback_reg),
		.ds_writeback_en_i(ds_writeback_en),
		.ds_branch_type_i(ds_branch_type),
		.ds_branch_offset_i(ds_branch_offset),
		.ds_branch_predicted_i(ds_branch_predicted),
		.rf_value1_i(rf_value1),
		.rf_value2_i(rf_value2),
		.ma_writeback_reg_i(ma_writeback_reg),
		.ma_writeback_en_i(ma_writeback_en),
		.ma_result_i(ma_result),
		.wb_writeback_reg_i(wb_writeback_reg),
		.wb_writeback_en_i(wb_writeback_en),
		.wb_result_i(wb_result),
		.rb_squash_i(rb_squash),
		.ex_valid_o(ex_valid),
		.ex_pc_o(ex_pc),
		.ex_writeback_reg_o(ex_writeback_reg),
		.ex_writeback_en_o(ex_writeback_en),
		.ex_result_o(ex_result),
		.ex_rollback_o(ex_rollback),
		.ex_rollback_pc_o(ex_rollback_pc)
	);

	always #5 clk = ~clk;

	function automatic logic [WORD_BITS - 1:0] xorshift(input logic [WORD_BITS - 1:0] x);
		logic [WORD_BITS - 1:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Expected single-cycle and multiply results
	function automatic logic [WORD_BITS - 1:0] alu_model(input alu_op_t op,
		input logic [WORD_BITS - 1:0] a, input logic [WORD_BITS - 1:0] b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR: return a | b;
			ALU_XOR: return a ^ b;
			ALU_SHL: return a << b[4:0];
			ALU_SHR: return a >> b[4:0];
			ALU_EQUAL: return (a == b) ? 32'd1 : 32'd0;
			ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_ULT: return (a < b) ? 32'd1 : 32'd0;
			ALU_MUL: return a * b;
			default: return 32'd0;
		endcase
	endfunction

	task automatic next_random(output logic [WORD_BITS - 1:0] value);
		rng_state = xorshift(rng_state);
		value = rng_state;
	endtask

	task automatic expect_word(input string name, input logic [WORD_BITS - 1:0] got,
		input logic [WORD_BITS - 1:0] exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("MISMATCH time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
		end
	endtask

	// Drive point just after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	// Check point well before the next edge
	task automatic wait_settle();
		#3;
	endtask

	task automatic clear_decode();
		ds_valid = 1'b0;
		ds_pc = '0;
		ds_alu_op = ALU_ADD;
		ds_sel1 = '0;
		ds_sel2 = '0;
		ds_op2_is_imm = 1'b0;
		ds_immediate = '0;
		ds_writeback_reg = '0;
		ds_writeback_en = 1'b0;
		ds_branch_type = BRANCH_NONE;
		ds_branch_offset = '0;
		ds_branch_predicted = 1'b0;
		rf_value1 = '0;
		rf_value2 = '0;
		rb_squash = '0;
	endtask

	task automatic clear_forwarding();
		ma_writeback_reg = '0;
		ma_writeback_en = 1'b0;
		ma_result = '0;
		wb_writeback_reg = '0;
		wb_writeback_en = 1'b0;
		wb_result = '0;
	endtask

	task automatic drive_op(input alu_op_t op, input logic [REG_BITS - 1:0] sel1,
		input logic [REG_BITS - 1:0] sel2, input logic [WORD_BITS - 1:0] rf1,
		input logic [WORD_BITS - 1:0] rf2, input logic [REG_BITS - 1:0] wreg,
		input logic [WORD_BITS - 1:0] pc);
		clear_decode();
		ds_valid = 1'b1;
		ds_alu_op = op;
		ds_sel1 = sel1;
		ds_sel2 = sel2;
		rf_value1 = rf1;
		rf_value2 = rf2;
		ds_writeback_reg = wreg;
		ds_writeback_en = 1'b1;
		ds_pc = pc;
	endtask

	task automatic check_ex(input logic exp_valid, input logic [WORD_BITS - 1:0] exp_pc,
		input logic [REG_BITS - 1:0] exp_reg, input logic exp_en,
		input logic [WORD_BITS - 1:0] exp_result);
		expect_bit("ex_valid_o", ex_valid, exp_valid);
		if (exp_valid)
		begin
			expect_word("ex_pc_o", ex_pc, exp_pc);
			expect_word("ex_writeback_reg_o", {27'd0, ex_writeback_reg}, {27'd0, exp_reg});
			expect_bit("ex_writeback_en_o", ex_writeback_en, exp_en);
			expect_word("ex_result_o", ex_result, exp_result);
		end
		else
			expect_bit("ex_writeback_en_o", ex_writeback_en, 1'b0);
	endtask

	task automatic test_short_ops();
		logic [WORD_BITS - 1:0] a;
		logic [WORD_BITS - 1:0] b;
		logic [WORD_BITS - 1:0] imm;
		logic [WORD_BITS - 1:0] pc;
		for (int i = 0; i < 10; i++)
		begin
			next_random(a);
			next_random(b);
			pc = 32'h0000_0100 + 32'(i) * 4;
			step_cycle();
			drive_op(alu_op_t'(i), 5'd1, 5'd2, a, b, 5'd3, pc);
			step_cycle();
			clear_decode();
			wait_settle();
			check_ex(1'b1, pc, 5'd3, 1'b1, alu_model(alu_op_t'(i), a, b));
		end
		// Equal operands give a true compare
		next_random(a);
		step_cycle();
		drive_op(ALU_EQUAL, 5'd1, 5'd2, a, a, 5'd3, 32'h0000_0180);
		step_cycle();
		clear_decode();
		wait_settle();
		check_ex(1'b1, 32'h0000_0180, 5'd3, 1'b1, 32'd1);
		// Immediate replaces the second register
		next_random(a);
		next_random(b);
		next_random(imm);
		step_cycle();
		drive_op(ALU_ADD, 5'd1, 5'd2, a, b, 5'd3, 32'h0000_0200);
		ds_op2_is_imm = 1'b1;
		ds_immediate = imm;
		step_cycle();
		clear_decode();
		wait_settle();
		check_ex(1'b1, 32'h0000_0200, 5'd3, 1'b1, alu_model(ALU_ADD, a, imm));
	endtask

	// Register 7 pending in ma as 111 and in wb as 222
	task automatic forward_add(input logic [REG_BITS - 1:0] sel1,
		input logic [WORD_BITS - 1:0] rf1, input logic [WORD_BITS - 1:0] pc,
		input logic ma_en, input logic wb_en, input logic [WORD_BITS - 1:0] expected);
		step_cycle();
		drive_op(ALU_ADD, sel1, 5'd0, rf1, 32'd0, 5'd8, pc);
		ds_op2_is_imm = 1'b1;
		ma_writeback_reg = 5'd7;
		ma_writeback_en = ma_en;
		ma_result = 32'd111;
		wb_writeback_reg = 5'd7;
		wb_writeback_en = wb_en;
		wb_result = 32'd222;
		step_cycle();
		clear_decode();
		clear_forwarding();
		wait_settle();
		check_ex(1'b1, pc, 5'd8, 1'b1, expected);
	endtask

	task automatic test_forwarding();
		// Dependent add picks up the ex result
		step_cycle();
		drive_op(ALU_ADD, 5'd1, 5'd2, 32'd10, 32'd20, 5'd5, 32'h0000_0300);
		step_cycle();
		drive_op(ALU_ADD, 5'd5, 5'd2, 32'hdead_beef, 32'd20, 5'd6, 32'h0000_0304);
		wait_settle();
		check_ex(1'b1, 32'h0000_0300, 5'd5, 1'b1, 32'd30);
		step_cycle();
		clear_decode();
		wait_settle();
		check_ex(1'b1, 32'h0000_0304, 5'd6, 1'b1, 32'd50);

		forward_add(5'd7, 32'd333, 32'h0000_0308, 1'b1, 1'b1, 32'd111);
		forward_add(5'd7, 32'd333, 32'h0000_030c, 1'b0, 1'b1, 32'd222);
		forward_add(5'd31, 32'h0000_5555, 32'h0000_0400, 1'b0, 1'b0, 32'h0000_0400);
	endtask

	// Three back-to-back multiplies with one optionally squashed on the way
	task automatic test_multiply(input int lost, input int squash_cycle,
		input logic [MUL_STAGES:0] squash_bits);
		logic [WORD_BITS - 1:0] a [3];
		logic [WORD_BITS - 1:0] b [3];
		logic [WORD_BITS - 1:0] pc [3];
		int k;
		for (int i = 0; i < 3; i++)
		begin
			next_random(a[i]);
			next_random(b[i]);
			pc[i] = 32'h0000_0500 + 32'(i) * 4;
		end
		for (int c = 0; c < MUL_LATENCY + 4; c++)
		begin
			step_cycle();
			if (c < 3)
				drive_op(ALU_MUL, 5'd1, 5'd2, a[c], b[c], 5'(10 + c), pc[c]);
			else
				clear_decode();
			if (c == squash_cycle)
				rb_squash = squash_bits;
			wait_settle();
			k = c - MUL_LATENCY;
			if (k >= 0 && k < 3 && k != lost)
				check_ex(1'b1, pc[k], 5'(10 + k), 1'b1, alu_model(ALU_MUL, a[k], b[k]));
			else if (c >= 1)
				check_ex(1'b0, 32'd0, 5'd0, 1'b0, 32'd0);
		end
	endtask

	// Operand register 4 optionally pending in ma or wb with fwd_value
	task automatic check_branch(input branch_t kind, input logic predicted,
		input logic [WORD_BITS - 1:0] pc, input logic [WORD_BITS - 1:0] operand,
		input logic ma_en, input logic wb_en, input logic [WORD_BITS - 1:0] fwd_value,
		input logic exp_rollback, input logic [WORD_BITS - 1:0] exp_pc);
		step_cycle();
		drive_op(ALU_ADD, 5'd4, 5'd0, operand, 32'd0, 5'd0, pc);
		ds_writeback_en = 1'b0;
		ds_branch_type = kind;
		ds_branch_offset = BRANCH_OFFSET;
		ds_branch_predicted = predicted;
		ma_writeback_reg = 5'd4;
		ma_writeback_en = ma_en;
		ma_result = fwd_value;
		wb_writeback_reg = 5'd4;
		wb_writeback_en = wb_en;
		wb_result = fwd_value;
		wait_settle();
		expect_bit("ex_rollback_o", ex_rollback, exp_rollback);
		if (exp_rollback)
			expect_word("ex_rollback_pc_o", ex_rollback_pc, exp_pc);
	endtask

	task automatic test_branches();
		check_branch(BRANCH_ZERO, 1'b0, 32'h0000_0600, 32'd5, 1'b1, 1'b0, 32'd0, 1'b1,
			32'h0000_0600 + BRANCH_OFFSET);
		check_branch(BRANCH_NOT_ZERO, 1'b1, 32'h0000_0610, 32'd0, 1'b0, 1'b1, 32'd7,
			1'b0, 32'd0);
		check_branch(BRANCH_NOT_ZERO, 1'b0, 32'h0000_0620, 32'd0, 1'b0, 1'b1, 32'd7,
			1'b1, 32'h0000_0620 + BRANCH_OFFSET);
		check_branch(BRANCH_ALWAYS, 1'b0, 32'h0000_0630, 32'd0, 1'b0, 1'b0, 32'd0, 1'b1,
			32'h0000_0630 + BRANCH_OFFSET);
		check_branch(BRANCH_ALWAYS, 1'b1, 32'h0000_0640, 32'd0, 1'b0, 1'b0, 32'd0, 1'b0,
			32'd0);
		// Predicted taken but falls through
		check_branch(BRANCH_ZERO, 1'b1, 32'h0000_0650, 32'd3, 1'b0, 1'b0, 32'd0, 1'b1,
			32'h0000_0650);

		// Add into the PC register is a jump to the sum
		step_cycle();
		drive_op(ALU_ADD, 5'd1, 5'd0, 32'h0000_1000, 32'd0, 5'd31, 32'h0000_0800);
		clear_forwarding();
		ds_op2_is_imm = 1'b1;
		ds_immediate = 32'h0000_0020;
		wait_settle();
		expect_bit("ex_rollback_o", ex_rollback, 1'b1);
		expect_word("ex_rollback_pc_o", ex_rollback_pc, 32'h0000_1020);
		step_cycle();
		clear_decode();
	endtask

	task automatic test_call();
		step_cycle();
		drive_op(ALU_ADD, 5'd3, 5'd0, 32'h0000_4000, 32'd0, 5'd30, 32'h0000_0900);
		ds_branch_type = BRANCH_CALL_REGISTER;
		wait_settle();
		expect_bit("ex_rollback_o", ex_rollback, 1'b1);
		expect_word("ex_rollback_pc_o", ex_rollback_pc, 32'h0000_4000);
		step_cycle();
		clear_decode();
		wait_settle();
		check_ex(1'b1, 32'h0000_0900, 5'd30, 1'b1, 32'h0000_0900);
	endtask

	task automatic test_issue_squash();
		step_cycle();
		drive_op(ALU_ADD, 5'd1, 5'd2, 32'd5, 32'd6, 5'd9, 32'h0000_0a00);
		rb_squash = 4'b0001;
		step_cycle();
		clear_decode();
		wait_settle();
		check_ex(1'b0, 32'd0, 5'd0, 1'b0, 32'd0);
	endtask

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		errors = 0;
		checks = 0;
		rng_state = 32'd82;
		clear_decode();
		clear_forwarding();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		wait_settle();
		check_ex(1'b0, 32'd0, 5'd0, 1'b0, 32'd0);
		expect_word("ex_result_o", ex_result, 32'd0);
		expect_word("ex_pc_o", ex_pc, 32'd0);

		test_short_ops();
		test_forwarding();
		test_multiply(-1, -1, 4'b0000);
		// Second multiply sits in stage 2 during cycle 3
		test_multiply(1, 3, 4'b0100);
		test_branches();
		test_call();
		test_issue_squash();

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
// Execute stage top level: operand bypass, ALU, branch check, multiplier and merge
`default_nettype none

module execute_stage
	import execute_pkg::*;
	#(parameter int MUL_STAGES = 3)
(
	input wire                  clk,
	input wire                  reset,

	// Decoded instruction
	input wire                  ds_valid_i,
	input wire word_t           ds_pc_i,
	input wire alu_op_t         ds_alu_op_i,
	input wire reg_idx_t        ds_sel1_i,
	input wire reg_idx_t        ds_sel2_i,
	input wire                  ds_op2_is_imm_i,
	input wire word_t           ds_immediate_i,
	input wire reg_idx_t        ds_writeback_reg_i,
	input wire                  ds_writeback_en_i,
	input wire branch_t         ds_branch_type_i,
	input wire word_t           ds_branch_offset_i,
	input wire                  ds_branch_predicted_i,

	// Register file read values
	input wire word_t           rf_value1_i,
	input wire word_t           rf_value2_i,

	// Later stages, for forwarding
	input wire reg_idx_t        ma_writeback_reg_i,
	input wire                  ma_writeback_en_i,
	input wire word_t           ma_result_i,
	input wire reg_idx_t        wb_writeback_reg_i,
	input wire                  wb_writeback_en_i,
	input wire word_t           wb_result_i,

	// Bit 0 is issue, bit k is multiply stage k
	input wire [MUL_STAGES:0]   rb_squash_i,

	output logic                ex_valid_o,
	output word_t               ex_pc_o,
	output reg_idx_t            ex_writeback_reg_o,
	output logic                ex_writeback_en_o,
	output word_t               ex_result_o,
	output logic                ex_rollback_o,
	output word_t               ex_rollback_pc_o
);

	word_t    operand1;
	word_t    value2;
	word_t    operand2;
	word_t    alu_result;
	logic     is_call;
	logic     issue_long;
	logic     issue_short;
	logic     mul_done;
	word_t    mul_result;
	word_t    mul_pc;
	reg_idx_t mul_writeback_reg;
	logic     mul_writeback_en;

	assign issue_long = ds_valid_i && !rb_squash_i[0] && (ds_alu_op_i == ALU_MUL);
	assign issue_short = ds_valid_i && !rb_squash_i[0] && (ds_alu_op_i != ALU_MUL);

	operand_bypass bypass1_i (
		.sel_i(ds_sel1_i),
		.pc_i(ds_pc_i),
		.rf_value_i(rf_value1_i),
		.ex_reg_i(ex_writeback_reg_o),
		.ex_en_i(ex_writeback_en_o),
		.ex_value_i(ex_result_o),
		.ma_reg_i(ma_writeback_reg_i),
		.ma_en_i(ma_writeback_en_i),
		.ma_value_i(ma_result_i),
		.wb_reg_i(wb_writeback_reg_i),
		.wb_en_i(wb_writeback_en_i),
		.wb_value_i(wb_result_i),
		.value_o(operand1)
	);

	operand_bypass bypass2_i (
		.sel_i(ds_sel2_i),
		.pc_i(ds_pc_i),
		.rf_value_i(rf_value2_i),
		.ex_reg_i(ex_writeback_reg_o),
		.ex_en_i(ex_writeback_en_o),
		.ex_value_i(ex_result_o),
		.ma_reg_i(ma_writeback_reg_i),
		.ma_en_i(ma_writeback_en_i),
		.ma_value_i(ma_result_i),
		.wb_reg_i(wb_writeback_reg_i),
		.wb_en_i(wb_writeback_en_i),
		.wb_value_i(wb_result_i),
		.value_o(value2)
	);

	assign operand2 = ds_op2_is_imm_i ? ds_immediate_i : value2;

	int_alu alu_i (
		.op_i(ds_alu_op_i),
		.operand1_i(operand1),
		.operand2_i(operand2),
		.result_o(alu_result)
	);

	branch_resolve branch_i (
		.valid_i(ds_valid_i),
		.short_i(issue_short),
		.pc_i(ds_pc_i),
		.branch_type_i(ds_branch_type_i),
		.offset_i(ds_branch_offset_i),
		.predicted_i(ds_branch_predicted_i),
		.operand1_i(operand1),
		.alu_result_i(alu_result),
		.writeback_reg_i(ds_writeback_reg_i),
		.writeback_en_i(ds_writeback_en_i),
		.taken_o(),
		.is_call_o(is_call),
		.rollback_o(ex_rollback_o),
		.rollback_pc_o(ex_rollback_pc_o)
	);

	multiply_pipe #(.MUL_STAGES(MUL_STAGES)) mul_i (
		.clk(clk),
		.reset(reset),
		.issue_i(issue_long),
		.operand1_i(operand1),
		.operand2_i(operand2),
		.pc_i(ds_pc_i),
		.writeback_reg_i(ds_writeback_reg_i),
		.writeback_en_i(ds_writeback_en_i),
		.squash_i(rb_squash_i[MUL_STAGES:1]),
		.done_o(mul_done),
		.result_o(mul_result),
		.pc_o(mul_pc),
		.writeback_reg_o(mul_writeback_reg),
		.writeback_en_o(mul_writeback_en)
	);

	result_merge #(.MUL_STAGES(MUL_STAGES)) merge_i (
		.clk(clk),
		.reset(reset),
		.short_i(issue_short),
		.pc_i(ds_pc_i),
		.writeback_reg_i(ds_writeback_reg_i),
		.writeback_en_i(ds_writeback_en_i),
		.alu_result_i(alu_result),
		.is_call_i(is_call),
		.mul_done_i(mul_done),
		.mul_result_i(mul_result),
		.mul_pc_i(mul_pc),
		.mul_writeback_reg_i(mul_writeback_reg),
		.mul_writeback_en_i(mul_writeback_en),
		.ex_valid_o(ex_valid_o),
		.ex_pc_o(ex_pc_o),
		.ex_writeback_reg_o(ex_writeback_reg_o),
		.ex_writeback_en_o(ex_writeback_en_o),
		.ex_result_o(ex_result_o)
	);

endmodule

`default_nettype wire

/* source/result_merge.sv */
// Merge of the single-cycle and multiply paths into the registered execute outputs
`default_nettype none

module result_merge
	import execute_pkg::*;
	#(parameter int MUL_STAGES = 3)
(
	input wire           clk,
	input wire           reset,

	// Short path, issue cycle
	input wire           short_i,
	input wire word_t    pc_i,
	input wire reg_idx_t writeback_reg_i,
	input wire           writeback_en_i,
	input wire word_t    alu_result_i,
	input wire           is_call_i,

	// Long path, last multiply stage
	input wire           mul_done_i,
	input wire word_t    mul_result_i,
	input wire word_t    mul_pc_i,
	input wire reg_idx_t mul_writeback_reg_i,
	input wire           mul_writeback_en_i,

	output logic         ex_valid_o,
	output word_t        ex_pc_o,
	output reg_idx_t     ex_writeback_reg_o,
	output logic         ex_writeback_en_o,
	output word_t        ex_result_o
);

	logic     valid_nxt;
	word_t    pc_nxt;
	reg_idx_t reg_nxt;
	logic     en_nxt;
	word_t    result_nxt;

	// Long path needs at least one stage
	if (MUL_STAGES < 1)
		$error("MUL_STAGES must be 1 or more");

	// Multiply has priority, the scheduler keeps the short path clear
	always_comb
	begin
		valid_nxt = 1'b0;
		pc_nxt = '0;
		reg_nxt = '0;
		en_nxt = 1'b0;
		result_nxt = '0;
		if (mul_done_i)
		begin
			valid_nxt = 1'b1;
			pc_nxt = mul_pc_i;
			reg_nxt = mul_writeback_reg_i;
			en_nxt = mul_writeback_en_i;
			result_nxt = mul_result_i;
		end
		else if (short_i)
		begin
			valid_nxt = 1'b1;
			pc_nxt = pc_i;
			reg_nxt = writeback_reg_i;
			en_nxt = writeback_en_i;
			// Link value for calls
			result_nxt = is_call_i ? pc_i : alu_result_i;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ex_valid_o <= 1'b0;
			ex_pc_o <= '0;
			ex_writeback_reg_o <= '0;
			ex_writeback_en_o <= 1'b0;
			ex_result_o <= '0;
		end
		else
		begin
			ex_valid_o <= valid_nxt;
			ex_pc_o <= pc_nxt;
			ex_writeback_reg_o <= reg_nxt;
			ex_writeback_en_o <= en_nxt;
			ex_result_o <= result_nxt;
		end
	end

	// Structural hazard at the merge point
	merge_conflict: assert property (@(posedge clk) disable iff (reset)
		!(mul_done_i && short_i))
	else
		$error("multiply and short op collide at the merge");

endmodule

`default_nettype wire

/* source/multiply_pipe.sv */
// Multi-stage multiplier carrying writeback metadata with per-stage squash
`default_nettype none

module multiply_pipe
	import execute_pkg::*;
	#(parameter int MUL_STAGES = 3)
(
	input wire                  clk,
	input wire                  reset,

	input wire                  issue_i,
	input wire word_t           operand1_i,
	input wire word_t           operand2_i,
	input wire word_t           pc_i,
	input wire reg_idx_t        writeback_reg_i,
	input wire                  writeback_en_i,

	// Bit k kills the entry now sitting in stage k
	input wire [MUL_STAGES:1]   squash_i,

	output logic                done_o,
	output word_t               result_o,
	output word_t               pc_o,
	output reg_idx_t            writeback_reg_o,
	output logic                writeback_en_o
);

	word_t                product;
	word_t                prod_q [1:MUL_STAGES];
	word_t                pc_q [1:MUL_STAGES];
	reg_idx_t             reg_q [1:MUL_STAGES];
	logic [MUL_STAGES:1]  valid_q;
	logic [MUL_STAGES:1]  en_q;

	// Low word only
	assign product = operand1_i * operand2_i;

	// Occupancy and write enable per stage
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_q <= '0;
			en_q <= '0;
		end
		else
		begin
			valid_q[1] <= issue_i;
			en_q[1] <= issue_i && writeback_en_i;
			for (int i = 2; i <= MUL_STAGES; i++)
			begin
				valid_q[i] <= valid_q[i - 1] && !squash_i[i - 1];
				en_q[i] <= en_q[i - 1] && !squash_i[i - 1];
			end
		end
	end

	// Payload follows the control bits
	always_ff @(posedge clk)
	begin
		if (issue_i)
		begin
			prod_q[1] <= product;
			pc_q[1] <= pc_i;
			reg_q[1] <= writeback_reg_i;
		end
		for (int i = 2; i <= MUL_STAGES; i++)
		begin
			prod_q[i] <= prod_q[i - 1];
			pc_q[i] <= pc_q[i - 1];
			reg_q[i] <= reg_q[i - 1];
		end
	end

	// Last squash bit kills the entry on its way out
	assign done_o = valid_q[MUL_STAGES] && !squash_i[MUL_STAGES];
	assign writeback_en_o = en_q[MUL_STAGES] && !squash_i[MUL_STAGES];
	assign result_o = prod_q[MUL_STAGES];
	assign pc_o = pc_q[MUL_STAGES];
	assign writeback_reg_o = reg_q[MUL_STAGES];

endmodule

`default_nettype wire

/* source/branch_resolve.sv */
// Branch condition and target evaluation with misprediction rollback request
`default_nettype none

module branch_resolve
	import execute_pkg::*;
(
	input wire           valid_i,
	input wire           short_i,
	input wire word_t    pc_i,
	input wire branch_t  branch_type_i,
	input wire word_t    offset_i,
	input wire           predicted_i,
	input wire word_t    operand1_i,
	input wire word_t    alu_result_i,
	input wire reg_idx_t writeback_reg_i,
	input wire           writeback_en_i,

	output logic         taken_o,
	output logic         is_call_o,
	output logic         rollback_o,
	output word_t        rollback_pc_o
);

	word_t target;
	logic  pc_write;

	// ALU result landing in the PC register acts as a jump
	assign pc_write = short_i && writeback_en_i && (writeback_reg_i == REG_PC);

	assign is_call_o = (branch_type_i == BRANCH_CALL_OFFSET)
		|| (branch_type_i == BRANCH_CALL_REGISTER);

	always_comb
	begin
		taken_o = 1'b0;
		target = pc_i + offset_i;
		if (pc_write)
		begin
			taken_o = 1'b1;
			target = alu_result_i;
		end
		else
		begin
			case (branch_type_i)
				BRANCH_ZERO:
					taken_o = operand1_i == '0;
				BRANCH_NOT_ZERO:
					taken_o = operand1_i != '0;
				BRANCH_ALWAYS, BRANCH_CALL_OFFSET, BRANCH_CALL_REGISTER:
					taken_o = 1'b1;
				default:
					taken_o = 1'b0;
			endcase

			// Indirect call jumps to the register value
			if (branch_type_i == BRANCH_CALL_REGISTER)
				target = operand1_i;
		end
	end

	// Wrong guess by decode restarts fetch on the real path
	assign rollback_o = valid_i && (predicted_i != taken_o);
	assign rollback_pc_o = taken_o ? target : pc_i;

endmodule

`default_nettype wire

/* source/int_alu.sv */
// Single-cycle integer ALU for the short execute path
`default_nettype none

module int_alu
	import execute_pkg::*;
(
	input wire alu_op_t op_i,
	input wire word_t   operand1_i,
	input wire word_t   operand2_i,
	output word_t       result_o
);

	logic [4:0] shift_amount;
	logic       equal;
	logic       less_signed;
	logic       less_unsigned;
	word_t      difference;

	assign shift_amount = operand2_i[4:0];
	assign difference = operand1_i - operand2_i;

	// Flags for the compare ops
	assign equal = operand1_i == operand2_i;
	assign less_signed = $signed(operand1_i) < $signed(operand2_i);
	assign less_unsigned = operand1_i < operand2_i;

	always_comb
	begin
		case (op_i)
			ALU_ADD:
				result_o = operand1_i + operand2_i;
			ALU_SUB:
				result_o = difference;
			ALU_AND:
				result_o = operand1_i & operand2_i;
			ALU_OR:
				result_o = operand1_i | operand2_i;
			ALU_XOR:
				result_o = operand1_i ^ operand2_i;
			ALU_SHL:
				result_o = operand1_i << shift_amount;
			ALU_SHR:
				result_o = operand1_i >> shift_amount;
			ALU_EQUAL:
				result_o = {{(DATA_WIDTH - 1){1'b0}}, equal};
			ALU_SLT:
				result_o = {{(DATA_WIDTH - 1){1'b0}}, less_signed};
			ALU_ULT:
				result_o = {{(DATA_WIDTH - 1){1'b0}}, less_unsigned};

			// Product comes from the multiply pipeline
			default:
				result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/operand_bypass.sv */
// Source operand forwarding mux over the ex, ma and wb results
`default_nettype none

module operand_bypass
	import execute_pkg::*;
(
	// Selected source register and its register-file value
	input wire reg_idx_t sel_i,
	input wire word_t    pc_i,
	input wire word_t    rf_value_i,

	// Result registered at the end of execute
	input wire reg_idx_t ex_reg_i,
	input wire           ex_en_i,
	input wire word_t    ex_value_i,

	// Memory access stage
	input wire reg_idx_t ma_reg_i,
	input wire           ma_en_i,
	input wire word_t    ma_value_i,

	// Writeback stage
	input wire reg_idx_t wb_reg_i,
	input wire           wb_en_i,
	input wire word_t    wb_value_i,

	output word_t        value_o
);

	logic ex_hit;
	logic ma_hit;
	logic wb_hit;

	assign ex_hit = ex_en_i && (ex_reg_i == sel_i);
	assign ma_hit = ma_en_i && (ma_reg_i == sel_i);
	assign wb_hit = wb_en_i && (wb_reg_i == sel_i);

	// Youngest producer wins, the PC register is never forwarded
	always_comb
	begin
		if (sel_i == REG_PC)
			value_o = pc_i;
		else if (ex_hit)
			value_o = ex_value_i;
		else if (ma_hit)
			value_o = ma_value_i;
		else if (wb_hit)
			value_o = wb_value_i;
		else
			value_o = rf_value_i;
	end

endmodule

`default_nettype wire

/* source/execute_pkg.sv */
// Execute stage package: word and register widths, typedefs, ALU and branch encodings
`default_nettype none

package execute_pkg;

	// Scalar datapath width
	localparam int DATA_WIDTH = 32;

	// Register index width, 32 architectural registers
	localparam int REG_IDX_WIDTH = 5;

	typedef logic [DATA_WIDTH - 1:0] word_t;
	typedef logic [REG_IDX_WIDTH - 1:0] reg_idx_t;

	// Reads as the PC, a write to it is a branch
	localparam reg_idx_t REG_PC = 5'd31;

	// Only ALU_MUL takes the long path
	typedef enum logic [3:0]
	{
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_OR    = 4'd3,
		ALU_XOR   = 4'd4,
		ALU_SHL   = 4'd5,
		ALU_SHR   = 4'd6,
		ALU_EQUAL = 4'd7,
		ALU_SLT   = 4'd8,
		ALU_ULT   = 4'd9,
		ALU_MUL   = 4'd10
	} alu_op_t;

	typedef enum logic [2:0]
	{
		BRANCH_NONE          = 3'd0,
		BRANCH_ZERO          = 3'd1,
		BRANCH_NOT_ZERO      = 3'd2,
		BRANCH_ALWAYS        = 3'd3,
		BRANCH_CALL_OFFSET   = 3'd4,
		BRANCH_CALL_REGISTER = 3'd5
	} branch_t;

endpackage

`default_nettype wire
